// File: dspDecoder.f
logic/decPkg.sv
logic/instrReg.sv
logic/instrClassify.sv
logic/regMoveDecode.sv
logic/opDecode.sv
logic/stagePipe.sv
logic/execControl.sv
logic/dspDecoder.sv
tb/dspDecoder_assert.sv
tb/dspDecoderTb.sv

// File: logic/decPkg.sv
package decPkg;

  localparam int instrWidth = 24;
  localparam int numFormats = 31;
  localparam int numCoreRegs = 16;
  localparam int numDagRegs = 8;
  localparam int pfxWidth = 9;  // Longest opcode prefix

  typedef logic [instrWidth-1:0] instrWord_t;
  typedef logic [numFormats:1] fmtVec_t;  // Bit n flags format n

  localparam int fmtDualMem = 1;
  localparam int fmtImmDm = 2;
  localparam int fmtDirect = 3;
  localparam int fmtCompDm = 4;
  localparam int fmtCompPm = 5;
  localparam int fmtImmReg = 6;
  localparam int fmtImmCreg = 7;
  localparam int fmtCompMove = 8;
  localparam int fmtCond = 9;
  localparam int fmtJump = 10;
  localparam int fmtShMemDm = 12;
  localparam int fmtShMemPm = 13;
  localparam int fmtShMove = 14;
  localparam int fmtShImm = 15;
  localparam int fmtShCond = 16;
  localparam int fmtRegMove = 17;
  localparam int fmtJumpInd = 19;
  localparam int fmtReturn = 20;
  localparam int fmtIo = 29;
  localparam int fmtNop = 30;

  typedef struct packed {
    logic [pfxWidth-1:0] code;  // Left aligned on the top opcode bits
    logic [3:0] len;
  } opPrefix_t;

  localparam opPrefix_t pfxDualMem = '{code: 9'b101_000000, len: 4'd3};
  localparam opPrefix_t pfxImmDm = '{code: 9'b11_0000000, len: 4'd2};
  localparam opPrefix_t pfxDirect = '{code: 9'b011_000000, len: 4'd3};
  localparam opPrefix_t pfxCompDm = '{code: 9'b100_000000, len: 4'd3};
  localparam opPrefix_t pfxCompPm = '{code: 9'b0100_00000, len: 4'd4};
  localparam opPrefix_t pfxImmReg = '{code: 9'b0101_00000, len: 4'd4};
  localparam opPrefix_t pfxImmCreg = '{code: 9'b00101_0000, len: 4'd5};
  localparam opPrefix_t pfxCompMove = '{code: 9'b0011_00000, len: 4'd4};
  localparam opPrefix_t pfxCond = '{code: 9'b00100_0000, len: 4'd5};
  localparam opPrefix_t pfxJump = '{code: 9'b000101_000, len: 4'd6};
  localparam opPrefix_t pfxShMemDm = '{code: 9'b00010001_0, len: 4'd8};
  localparam opPrefix_t pfxShMemPm = '{code: 9'b0001001_00, len: 4'd7};
  localparam opPrefix_t pfxShMove = '{code: 9'b00001111_0, len: 4'd8};
  localparam opPrefix_t pfxShImm = '{code: 9'b00010000_0, len: 4'd8};
  localparam opPrefix_t pfxShCond = '{code: 9'b00001101_0, len: 4'd8};
  localparam opPrefix_t pfxRegMove = '{code: 9'b00001110_0, len: 4'd8};
  localparam opPrefix_t pfxJumpInd = '{code: 9'b00001100_0, len: 4'd8};
  localparam opPrefix_t pfxReturn = '{code: 9'b00001001_0, len: 4'd8};
  localparam opPrefix_t pfxIo = '{code: 9'b000000100, len: 4'd9};
  localparam opPrefix_t pfxNop = '{code: 9'b000000101, len: 4'd9};

  localparam logic [3:0] regAX0 = 4'd0;
  localparam logic [3:0] regAX1 = 4'd1;
  localparam logic [3:0] regMX0 = 4'd2;
  localparam logic [3:0] regMX1 = 4'd3;
  localparam logic [3:0] regAY0 = 4'd4;
  localparam logic [3:0] regAY1 = 4'd5;
  localparam logic [3:0] regMY0 = 4'd6;
  localparam logic [3:0] regMY1 = 4'd7;
  localparam logic [3:0] regSI = 4'd8;
  localparam logic [3:0] regSE = 4'd9;
  localparam logic [3:0] regAR = 4'd10;
  localparam logic [3:0] regMR0 = 4'd11;
  localparam logic [3:0] regMR1 = 4'd12;
  localparam logic [3:0] regMR2 = 4'd13;
  localparam logic [3:0] regSR0 = 4'd14;
  localparam logic [3:0] regSR1 = 4'd15;

  localparam logic [5:0] dagIBase0 = 6'h10;
  localparam logic [5:0] dagMBase0 = 6'h14;
  localparam logic [5:0] dagLBase0 = 6'h18;
  localparam logic [5:0] dagIBase1 = 6'h20;
  localparam logic [5:0] dagMBase1 = 6'h24;
  localparam logic [5:0] dagLBase1 = 6'h28;

  typedef struct packed {
    logic [numCoreRegs-1:0] mtCore;
    logic [numCoreRegs-1:0] mfCore;
    logic [numDagRegs-1:0] mtI;
    logic [numDagRegs-1:0] mtM;
    logic [numDagRegs-1:0] mtL;
    logic [numDagRegs-1:0] mfI;
    logic [numDagRegs-1:0] mfM;
    logic [numDagRegs-1:0] mfL;
  } regMove_t;

  typedef struct packed {
    logic aluOp;
    logic macOp;
    logic shtOp;
    logic updAR;
    logic updAF;
    logic updMR;
    logic updMF;
    logic updSR;
    logic usesCond;
  } opCtl_t;

  typedef struct packed {
    logic pRead;
    logic pWrite;
    logic dRead;
    logic dWrite;
    logic ioRead;
    logic ioWrite;
    logic post1;
    logic post2;
    logic dual;
  } memAccess_t;

  typedef struct packed {
    logic nonSeq;
    logic branch;
    logic call;
    logic rts;
    logic rti;
  } flowCtl_t;

endpackage

// File: logic/dspDecoder.sv
`timescale 1ns/10ps

module dspDecoder (
  input  logic DSPCLK,
  input  logic PPclr,
  input  decPkg::instrWord_t instrWord,
  input  logic goD,
  input  logic goE,
  input  logic goC,
  input  logic prdErr,
  input  logic condTrue,
  output decPkg::instrWord_t ir,
  output decPkg::instrWord_t irE,
  output decPkg::fmtVec_t fmt,
  output decPkg::regMove_t regMoveE,
  output decPkg::opCtl_t opCtlE,
  output decPkg::memAccess_t memE,
  output decPkg::flowCtl_t flowE,
  output logic dummyE,
  output logic exEn,
  output logic exEnc
);
  import decPkg::*;

  regMove_t regMoveR;
  opCtl_t opCtlR;
  memAccess_t memR;
  flowCtl_t flowR;

  instrReg u_instrReg (.DSPCLK, .PPclr, .instrWord, .goD, .goE, .ir, .irE);

  instrClassify u_instrClassify (.ir, .fmt);

  regMoveDecode u_regMoveDecode (.ir, .fmt, .regMove(regMoveR));

  opDecode u_opDecode (.ir, .fmt, .opCtl(opCtlR), .mem(memR), .flow(flowR));

  stagePipe #(.payload_t(regMove_t)) u_regMovePipe (.DSPCLK, .PPclr, .goE, .goC,
    .dIn(regMoveR), .qE(regMoveE), .qC());

  stagePipe #(.payload_t(opCtl_t)) u_opCtlPipe (.DSPCLK, .PPclr, .goE, .goC,
    .dIn(opCtlR), .qE(opCtlE), .qC());

  stagePipe #(.payload_t(memAccess_t)) u_memPipe (.DSPCLK, .PPclr, .goE, .goC,
    .dIn(memR), .qE(memE), .qC());

  execControl u_execControl (.DSPCLK, .PPclr, .goE, .goC, .prdErr, .condTrue,
    .usesCondE(opCtlE.usesCond), .flowR, .flowE, .dummyE, .exEn, .exEnc);

endmodule

// File: logic/execControl.sv
`timescale 1ns/10ps

module execControl (
  input  logic DSPCLK,
  input  logic PPclr,
  input  logic goE,
  input  logic goC,
  input  logic prdErr,
  input  logic condTrue,
  input  logic usesCondE,
  input  decPkg::flowCtl_t flowR,
  output decPkg::flowCtl_t flowE,
  output logic dummyE,
  output logic exEn,
  output logic exEnc
);

  logic prdErrC;
  logic dummyR;

  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      prdErrC <= 1'b0;
    end else if (goC) begin
      prdErrC <= prdErr;  // Read error follows its instruction to commit
    end
  end

  assign dummyR = prdErr || prdErrC;

  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      dummyE <= 1'b0;
      flowE <= '0;
    end else if (goE) begin
      dummyE <= dummyR;
      flowE <= dummyR ? '0 : flowR;  // No flow change from a dummy cycle
    end
  end

  assign exEn = !dummyE;
  assign exEnc = exEn && (!usesCondE || condTrue);

endmodule

// File: logic/instrClassify.sv
`timescale 1ns/10ps

module instrClassify (
  input  decPkg::instrWord_t ir,
  output decPkg::fmtVec_t fmt
);
  import decPkg::*;

  function automatic logic hit(input instrWord_t word, input opPrefix_t pfx);
    logic [pfxWidth-1:0] mask;
    mask = ~({pfxWidth{1'b1}} >> pfx.len);  // Keep only the prefix bits
    return (word[instrWidth-1 -: pfxWidth] & mask) == (pfx.code & mask);
  endfunction

  // Prefixes are disjoint, so at most one bit is set
  always_comb begin
    fmt = '0;
    fmt[fmtDualMem] = hit(ir, pfxDualMem);
    fmt[fmtImmDm] = hit(ir, pfxImmDm);
    fmt[fmtDirect] = hit(ir, pfxDirect);
    fmt[fmtCompDm] = hit(ir, pfxCompDm);
    fmt[fmtCompPm] = hit(ir, pfxCompPm);
    fmt[fmtImmReg] = hit(ir, pfxImmReg);
    fmt[fmtImmCreg] = hit(ir, pfxImmCreg);
    fmt[fmtCompMove] = hit(ir, pfxCompMove);
    fmt[fmtCond] = hit(ir, pfxCond);
    fmt[fmtJump] = hit(ir, pfxJump);
    fmt[fmtShMemDm] = hit(ir, pfxShMemDm);
    fmt[fmtShMemPm] = hit(ir, pfxShMemPm);
    fmt[fmtShMove] = hit(ir, pfxShMove);
    fmt[fmtShImm] = hit(ir, pfxShImm);
    fmt[fmtShCond] = hit(ir, pfxShCond);
    fmt[fmtRegMove] = hit(ir, pfxRegMove);
    fmt[fmtJumpInd] = hit(ir, pfxJumpInd);
    fmt[fmtReturn] = hit(ir, pfxReturn);
    fmt[fmtIo] = hit(ir, pfxIo);
    fmt[fmtNop] = hit(ir, pfxNop);
  end

endmodule

// File: logic/instrReg.sv
`timescale 1ns/10ps

module instrReg (
  input  logic DSPCLK,
  input  logic PPclr,
  input  decPkg::instrWord_t instrWord,
  input  logic goD,
  input  logic goE,
  output decPkg::instrWord_t ir,
  output decPkg::instrWord_t irE
);

  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      ir <= '0;
    end else if (goD) begin
      ir <= instrWord;  // Fetched word enters decode
    end
  end

  // Operand fields are read from this copy during execute
  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      irE <= '0;
    end else if (goE) begin
      irE <= ir;
    end
  end

endmodule

// File: logic/opDecode.sv
`timescale 1ns/10ps

module opDecode (
  input  decPkg::instrWord_t ir,
  input  decPkg::fmtVec_t fmt,
  output decPkg::opCtl_t opCtl,
  output decPkg::memAccess_t mem,
  output decPkg::flowCtl_t flow
);
  import decPkg::*;

  logic compFmt;
  logic dual;
  logic [4:0] amf;

  assign amf = ir[17:13];  // ALU/MAC function field
  assign dual = fmt[fmtDualMem];
  assign compFmt = fmt[fmtDualMem] || fmt[fmtCompDm] || fmt[fmtCompPm] ||
                   fmt[fmtCompMove] || fmt[fmtCond];

  assign opCtl.aluOp = compFmt && amf[4];
  assign opCtl.macOp = compFmt && !amf[4] && (|amf[3:0]);
  assign opCtl.shtOp = fmt[fmtShMemDm] || fmt[fmtShMemPm] || fmt[fmtShMove] ||
                       fmt[fmtShImm] || fmt[fmtShCond];
  // Bit 18 steers the result to the feedback register
  assign opCtl.updAR = opCtl.aluOp && (!ir[18] || dual);
  assign opCtl.updAF = opCtl.aluOp && ir[18] && !dual;
  assign opCtl.updMR = opCtl.macOp && (!ir[18] || dual);
  assign opCtl.updMF = opCtl.macOp && ir[18] && !dual;
  assign opCtl.updSR = opCtl.shtOp && (ir[14:13] != 2'b11);
  assign opCtl.usesCond = fmt[fmtCond] || fmt[fmtJump] || fmt[fmtShCond] ||
                          fmt[fmtJumpInd] || fmt[fmtReturn];

  assign mem.pRead = dual || (fmt[fmtCompPm] && !ir[19]) ||
                     (fmt[fmtShMemPm] && !ir[15]);
  assign mem.pWrite = (fmt[fmtCompPm] && ir[19]) || (fmt[fmtShMemPm] && ir[15]);
  assign mem.dRead = dual || (fmt[fmtDirect] && !ir[20]) ||
                     (fmt[fmtCompDm] && !ir[19]) || (fmt[fmtShMemDm] && !ir[15]);
  assign mem.dWrite = fmt[fmtImmDm] || (fmt[fmtDirect] && ir[20]) ||
                      (fmt[fmtCompDm] && ir[19]) || (fmt[fmtShMemDm] && ir[15]);
  assign mem.ioRead = fmt[fmtIo] && !ir[15];
  assign mem.ioWrite = fmt[fmtIo] && ir[15];
  assign mem.post1 = dual || (fmt[fmtShMemDm] && !ir[16]) ||
                     ((fmt[fmtImmDm] || fmt[fmtCompDm]) && !ir[20]);
  // Program memory is always addressed by the second unit
  assign mem.post2 = dual || fmt[fmtCompPm] || fmt[fmtShMemPm] ||
                     (fmt[fmtShMemDm] && ir[16]) ||
                     ((fmt[fmtImmDm] || fmt[fmtCompDm]) && ir[20]);
  assign mem.dual = dual;

  assign flow.branch = fmt[fmtJump] || fmt[fmtJumpInd];
  assign flow.call = (fmt[fmtJump] && ir[18]) || (fmt[fmtJumpInd] && ir[4]);
  assign flow.rts = fmt[fmtReturn] && !ir[4];
  assign flow.rti = fmt[fmtReturn] && ir[4];
  assign flow.nonSeq = flow.branch || fmt[fmtReturn];

endmodule

// File: logic/regMoveDecode.sv
`timescale 1ns/10ps

module regMoveDecode (
  input  decPkg::instrWord_t ir,
  input  decPkg::fmtVec_t fmt,
  output decPkg::regMove_t regMove
);
  import decPkg::*;

  logic [5:0] dCode;
  logic [5:0] sCode;
  logic mtReg;
  logic mfReg;
  logic [numCoreRegs-1:0] dualLoad;

  function automatic logic [numCoreRegs-1:0] coreSel(input logic [5:0] code);
    coreSel = '0;
    if (code[5:4] == 2'b00)
      coreSel[code[3:0]] = 1'b1;
  endfunction

  // Each DAG group holds four registers at an aligned base
  function automatic logic [numDagRegs-1:0] dagSel(input logic [5:0] code,
      input logic [5:0] base0, input logic [5:0] base1);
    dagSel = '0;
    if (code[5:2] == base0[5:2])
      dagSel[{1'b0, code[1:0]}] = 1'b1;
    else if (code[5:2] == base1[5:2])
      dagSel[{1'b1, code[1:0]}] = 1'b1;
  endfunction

  assign dCode[5:4] = fmt[fmtRegMove] ? ir[11:10] :
                      (fmt[fmtDirect] || fmt[fmtImmCreg]) ? ir[19:18] : 2'b00;
  assign dCode[3:0] = (fmt[fmtDirect] || fmt[fmtImmReg] || fmt[fmtImmCreg] ||
                       fmt[fmtIo]) ? ir[3:0] : ir[7:4];
  assign sCode[5:4] = fmt[fmtRegMove] ? ir[9:8] :
                      fmt[fmtDirect] ? ir[19:18] : 2'b00;
  assign sCode[3:0] = (fmt[fmtDirect] || fmt[fmtCompMove] || fmt[fmtShMove] ||
                       fmt[fmtRegMove] || fmt[fmtIo]) ? ir[3:0] : ir[7:4];

  assign mtReg = (fmt[fmtDirect] && !ir[20]) || fmt[fmtImmCreg] || fmt[fmtRegMove] ||
                 ((fmt[fmtCompDm] || fmt[fmtCompPm]) && !ir[19]) ||
                 fmt[fmtImmReg] || fmt[fmtCompMove] || fmt[fmtShMove] ||
                 ((fmt[fmtShMemDm] || fmt[fmtShMemPm] || fmt[fmtIo]) && !ir[15]);
  assign mfReg = fmt[fmtCompMove] || fmt[fmtShMove] || fmt[fmtRegMove] ||
                 (fmt[fmtDirect] && ir[20]) ||
                 ((fmt[fmtCompDm] || fmt[fmtCompPm]) && ir[19]) ||
                 ((fmt[fmtShMemDm] || fmt[fmtShMemPm] || fmt[fmtIo]) && ir[15]);

  // Dual memory read fills one X and one Y operand register
  assign dualLoad = fmt[fmtDualMem] ?
                    (coreSel({2'b00, regAX0 + ir[19:18]}) |
                     coreSel({2'b00, regAY0 + ir[21:20]})) : '0;

  always_comb begin
    regMove = '0;
    if (mtReg) begin
      regMove.mtCore = coreSel(dCode);
      regMove.mtI = dagSel(dCode, dagIBase0, dagIBase1);
      regMove.mtM = dagSel(dCode, dagMBase0, dagMBase1);
      regMove.mtL = dagSel(dCode, dagLBase0, dagLBase1);
    end
    if (mfReg) begin
      regMove.mfCore = coreSel(sCode);
      regMove.mfI = dagSel(sCode, dagIBase0, dagIBase1);
      regMove.mfM = dagSel(sCode, dagMBase0, dagMBase1);
      regMove.mfL = dagSel(sCode, dagLBase0, dagLBase1);
    end
    regMove.mtCore = regMove.mtCore | dualLoad;
  end

endmodule

// File: logic/stagePipe.sv
`timescale 1ns/10ps

module stagePipe #(
  parameter type payload_t = logic
) (
  input  logic DSPCLK,
  input  logic PPclr,
  input  logic goE,
  input  logic goC,
  input  payload_t dIn,
  output payload_t qE,
  output payload_t qC
);

  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      qE <= '0;
    end else if (goE) begin
      qE <= dIn;  // Decoded payload enters execute
    end
  end

  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      qC <= '0;
    end else if (goC) begin
      qC <= qE;
    end
  end

endmodule

// File: runSim.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module dspDecoderTb \
    -f dspDecoder.f; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/VdspDecoderTb)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1

// File: tb/dspDecoderTb.sv
`timescale 1ns/10ps

module dspDecoderTb;
  import decPkg::*;

  localparam int maxCycles = 400;  // Tests take under 100 cycles

  logic DSPCLK, PPclr, goD, goE, goC, prdErr, condTrue;
  logic dummyE, exEn, exEnc;
  instrWord_t instrWord, ir, irE;
  fmtVec_t fmt;
  regMove_t regMoveE;
  opCtl_t opCtlE;
  memAccess_t memE;
  flowCtl_t flowE;
  int cycleCount, checkCount, errCount, testErrs, testCount;
  bit runEnded;

  dspDecoder u_dspDecoder (.DSPCLK, .PPclr, .instrWord, .goD, .goE, .goC, .prdErr,
    .condTrue, .ir, .irE, .fmt, .regMoveE, .opCtlE, .memE, .flowE, .dummyE, .exEn, .exEnc);

  bind dspDecoder dspDecoderAssert u_dspDecoderAssert (.DSPCLK, .PPclr, .goE,
    .dummyR(u_execControl.dummyR), .dummyE, .exEn, .regMoveE, .memE, .flowE);

  always #20 DSPCLK = ~DSPCLK;

  always @(posedge DSPCLK) begin
    cycleCount++;
    if (cycleCount > maxCycles) begin
      runEnded = 1'b1;
      $display("Timeout: run still going after %0d cycles", maxCycles);
      $display("Checks failed");
      $finish;
    end
  end

  final begin
    if (!runEnded) begin
      $display("Run ended before all tests finished");
      $display("Checks failed");
    end
  end

  task automatic flagError(input string msg);
    errCount++;
    testErrs++;
    $display("** Error at %0d ns: %s", $time, msg);
  endtask

  task automatic checkBit(input logic got, input logic exp, input string what);
    checkCount++;
    if (got !== exp)
      flagError($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic checkWord(input instrWord_t got, input instrWord_t exp, input string what);
    checkCount++;
    if (got !== exp)
      flagError($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic checkFmt(input fmtVec_t got, input fmtVec_t exp, input string what);
    checkCount++;
    if (got !== exp)
      flagError($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic checkRegMove(input regMove_t got, input regMove_t exp, input string what);
    checkCount++;
    if (got !== exp)
      flagError($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic checkOpCtl(input opCtl_t got, input opCtl_t exp, input string what);
    checkCount++;
    if (got !== exp)
      flagError($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic checkMem(input memAccess_t got, input memAccess_t exp, input string what);
    checkCount++;
    if (got !== exp)
      flagError($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic checkFlow(input flowCtl_t got, input flowCtl_t exp, input string what);
    checkCount++;
    if (got !== exp)
      flagError($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  // Called on a falling edge, returns on the next one with strobes low
  task automatic strobe(input logic d, input logic e, input logic c, input logic err);
    goD = d;
    goE = e;
    goC = c;
    prdErr = err;
    @(negedge DSPCLK);
    {goD, goE, goC, prdErr} = '0;
  endtask

  task automatic applyReset();
    PPclr = 1'b1;
    repeat (2) @(negedge DSPCLK);
    PPclr = 1'b0;
  endtask

  function automatic fmtVec_t formatFlag(input int idx);
    formatFlag = '0;
    formatFlag[idx] = 1'b1;
  endfunction

  task automatic issue(input instrWord_t word, input int fmtIdx);
    instrWord = word;
    strobe(1, 0, 0, 0);
    checkWord(ir, word, "ir after goD");
    checkFmt(fmt, formatFlag(fmtIdx), $sformatf("fmt of %h", word));
    strobe(0, 1, 0, 0);
    checkWord(irE, word, "irE after goE");
  endtask

  task automatic endTest(input string name);
    $display("%s test finished with %0d errors", name, testErrs);
    testErrs = 0;
    testCount++;
  endtask

  // Random code naming a core register or one of the I, M, L groups
  function automatic logic [5:0] pickCode();
    logic [1:0] grp;
    logic [3:0] nib;
    grp = 2'($urandom_range(2));
    nib = (grp == 2'd0) ? 4'($urandom_range(15)) : 4'($urandom_range(11));
    return {grp, nib};
  endfunction

  function automatic logic [7:0] dagOneHot(input logic [5:0] code, input logic [5:0] b0,
      input logic [5:0] b1);
    dagOneHot = '0;
    for (int k = 0; k < 4; k++) begin
      if (code == b0 + 6'(k))
        dagOneHot[k] = 1'b1;
      if (code == b1 + 6'(k))
        dagOneHot[k + 4] = 1'b1;
    end
  endfunction

  task automatic resetTest();
    issue({6'b000101, 18'h0}, fmtJump);
    applyReset();
    checkWord(ir, '0, "ir after reset");
    checkWord(irE, '0, "irE after reset");
    checkOpCtl(opCtlE, '0, "opCtlE after reset");
    checkFlow(flowE, '0, "flowE after reset");
    instrWord = {3'b100, 3'b000, 5'b10000, 5'h0, 4'h3, 4'h0};  // ALU op, loads MX1
    strobe(1, 0, 0, 0);
    strobe(0, 1, 0, 1);  // Squashed, so dummyE is set
    strobe(0, 0, 1, 1);  // Leaves a read error in commit
    applyReset();
    checkRegMove(regMoveE, '0, "regMoveE after reset");
    checkMem(memE, '0, "memE after reset");
    checkBit(dummyE, 1'b0, "dummyE after reset");
    checkBit(exEn, 1'b1, "exEn after reset");
    strobe(0, 1, 0, 0);
    checkBit(dummyE, 1'b0, "dummyE with commit error cleared");
    endTest("reset");
  endtask

  task automatic regMoveTest();
    logic [5:0] d;
    logic [5:0] s;
    regMove_t e;
    for (int n = 0; n < 16; n++) begin
      d = pickCode();
      s = pickCode();
      issue({8'b00001110, 4'h0, d[5:4], s[5:4], d[3:0], s[3:0]}, fmtRegMove);
      e = '0;
      if (d < 6'h10)
        e.mtCore[d[3:0]] = 1'b1;
      if (s < 6'h10)
        e.mfCore[s[3:0]] = 1'b1;
      e.mtI = dagOneHot(d, dagIBase0, dagIBase1);
      e.mtM = dagOneHot(d, dagMBase0, dagMBase1);
      e.mtL = dagOneHot(d, dagLBase0, dagLBase1);
      e.mfI = dagOneHot(s, dagIBase0, dagIBase1);
      e.mfM = dagOneHot(s, dagMBase0, dagMBase1);
      e.mfL = dagOneHot(s, dagLBase0, dagLBase1);
      checkRegMove(regMoveE, e, $sformatf("regMoveE dst %h src %h", d, s));
    end
    endTest("register move");
  endtask

  task automatic computeTest();
    logic [4:0] amf;
    logic f;
    opCtl_t e;
    for (int n = 0; n < 6; n++) begin
      f = (n >= 3);
      if (n % 3 == 0)
        amf = {1'b1, 4'($urandom)};
      else if (n % 3 == 1)
        amf = {1'b0, 4'($urandom_range(15, 1))};
      else
        amf = 5'b0;
      issue({5'b00100, f, amf, 13'h0}, fmtCond);
      e = '0;
      e.aluOp = amf[4];
      e.macOp = !amf[4] && (amf[3:0] != 4'h0);
      e.updAR = e.aluOp && !f;
      e.updAF = e.aluOp && f;
      e.updMR = e.macOp && !f;
      e.updMF = e.macOp && f;
      e.usesCond = 1'b1;
      checkOpCtl(opCtlE, e, $sformatf("opCtlE amf %b bit18 %b", amf, f));
      condTrue = 1'b0;
      strobe(0, 0, 0, 0);
      checkBit(exEnc, 1'b0, "exEnc with condition false");
      condTrue = 1'b1;
      strobe(0, 0, 0, 0);
      checkBit(exEnc, 1'b1, "exEnc with condition true");
    end
    condTrue = 1'b0;
    endTest("compute");
  endtask

  task automatic memoryTest();
    memAccess_t e;
    for (int n = 0; n < 4; n++) begin
      issue({3'b100, n[1], n[0], 19'h0}, fmtCompDm);
      e = '0;
      e.dRead = !n[0];
      e.dWrite = n[0];
      e.post1 = !n[1];
      e.post2 = n[1];
      checkMem(memE, e, $sformatf("memE bits 20:19 %0d", n));
      checkOpCtl(opCtlE, '0, "opCtlE format 4");
      checkBit(exEnc, 1'b1, "exEnc unconditional");
    end
    endTest("memory");
  endtask

  task automatic flowTest();
    flowCtl_t jump;
    jump = '0;
    jump.nonSeq = 1'b1;
    jump.branch = 1'b1;
    jump.call = 1'b1;
    issue({6'b000101, 18'h0}, fmtJump);
    checkFlow(flowE, jump, "flowE jump call");
    strobe(0, 1, 0, 1);
    checkFlow(flowE, '0, "flowE squashed");
    checkBit(dummyE, 1'b1, "dummyE on read error");
    checkBit(exEn, 1'b0, "exEn on read error");
    strobe(0, 0, 1, 1);
    issue({6'b000101, 18'h0}, fmtJump);
    checkFlow(flowE, '0, "flowE squashed from commit");
    checkBit(dummyE, 1'b1, "dummyE from commit");
    strobe(0, 0, 1, 0);
    strobe(0, 1, 0, 0);
    checkFlow(flowE, jump, "flowE after error clears");
    checkBit(dummyE, 1'b0, "dummyE after error clears");
    endTest("flow");
  endtask

  initial begin
    void'($urandom(32'he4af));
    DSPCLK = 1'b0;
    PPclr = 1'b1;
    instrWord = '0;
    {goD, goE, goC, prdErr, condTrue} = '0;
    applyReset();
    resetTest();
    regMoveTest();
    computeTest();
    memoryTest();
    flowTest();
    $display("Tests run %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
    runEnded = 1'b1;
    if (errCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: tb/dspDecoder_assert.sv
`timescale 1ns/10ps

module dspDecoderAssert (
  input logic DSPCLK,
  input logic PPclr,
  input logic goE,
  input logic dummyR,
  input logic dummyE,
  input logic exEn,
  input decPkg::regMove_t regMoveE,
  input decPkg::memAccess_t memE,
  input decPkg::flowCtl_t flowE
);

  noRunOnDummy: assert property (@(posedge DSPCLK) disable iff (PPclr) dummyE |-> !exEn)
    else $error("exEn set during a dummy cycle");

  // Dual loads fill an X and a Y register at once
  oneCoreDest: assert property (@(posedge DSPCLK) disable iff (PPclr)
    !memE.dual |-> $onehot0(regMoveE.mtCore))
    else $error("more than one core destination selected");

  callIsBranch: assert property (@(posedge DSPCLK) disable iff (PPclr)
    flowE.call |-> flowE.branch)
    else $error("call request without branch");

  squashNoFlow: assert property (@(posedge DSPCLK) disable iff (PPclr)
    (goE && dummyR) |=> (flowE == '0))
    else $error("flow request from a squashed instruction");

endmodule
